//--- logic/riscv_isa_pkg.sv
/*
 * RV64I/M instruction encodings
 * Major opcode enum, base instruction field layout, immediate formats
 */

package riscv_isa_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int unsigned ILEN = 32;  // No compressed support

  // ------------------------------------------------------------------------
  // Major opcodes, bits [6:0]
  // ------------------------------------------------------------------------
  typedef enum logic [6:0] {
    OPCODE_LUI       = 7'b0110111,
    OPCODE_AUIPC     = 7'b0010111,
    OPCODE_JAL       = 7'b1101111,
    OPCODE_JALR      = 7'b1100111,
    OPCODE_BRANCH    = 7'b1100011,
    OPCODE_LOAD      = 7'b0000011,
    OPCODE_STORE     = 7'b0100011,
    OPCODE_OP_IMM    = 7'b0010011,
    OPCODE_OP_IMM_32 = 7'b0011011,  // ADDIW and W shifts
    OPCODE_OP        = 7'b0110011,
    OPCODE_OP_32     = 7'b0111011   // W register ops
  } opcode_e;

  // R-type view of a 32-bit word
  // Other formats reuse these slices and imm_gen picks the immediate bits
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instr_t;

  // Which immediate layout a decoded instruction carries
  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_I    = 3'd1,
    IMM_S    = 3'd2,
    IMM_B    = 3'd3,
    IMM_U    = 3'd4,
    IMM_J    = 3'd5
  } imm_fmt_e;

endpackage

//--- logic/decode_pkg.sv
/*
 * Decode stage micro-op definitions
 * Widths, FU and operation enums, fetch slot and micro-op structs
 */

package decode_pkg;

  // ------------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------------
  localparam int unsigned XLEN         = 64;
  localparam int unsigned PLEN         = 40;  // Physical address
  localparam int unsigned DECODE_WIDTH = 2;   // Lanes per bundle

  // ------------------------------------------------------------------------
  // Operation encodings
  // ------------------------------------------------------------------------
  typedef enum logic [2:0] {
    FU_ALU    = 3'd0,
    FU_BRANCH = 3'd1,
    FU_LSU    = 3'd2,
    FU_MUL    = 3'd3,
    FU_DIV    = 3'd4
  } fu_e;

  typedef enum logic [3:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_OR,
    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_AUIPC
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR
  } br_op_e;

  typedef enum logic [3:0] {
    LSU_LB, LSU_LH, LSU_LW, LSU_LD, LSU_LBU, LSU_LHU, LSU_LWU,
    LSU_SB, LSU_SH, LSU_SW, LSU_SD
  } lsu_op_e;

  // ------------------------------------------------------------------------
  // Bundle structs
  // ------------------------------------------------------------------------
  // One slot from the instruction buffer
  typedef struct packed {
    logic                  slot_valid;
    riscv_isa_pkg::instr_t instr;
    logic [PLEN-1:0]       pc;
    logic [PLEN-1:0]       pred_npc;
  } fetch_slot_t;

  // Per-lane control produced by rv_op_decoder
  typedef struct packed {
    logic                    illegal;
    fu_e                     fu;
    alu_op_e                 alu_op;
    br_op_e                  br_op;
    lsu_op_e                 lsu_op;
    logic                    has_rs1;
    logic                    has_rs2;
    logic                    has_rd;
    logic                    is_load;
    logic                    is_store;
    logic                    is_branch;
    logic                    is_jump;
    logic                    is_word_op;
    riscv_isa_pkg::imm_fmt_e imm_fmt;
  } dec_ctrl_t;

  // Micro-op handed to rename
  typedef struct packed {
    logic            valid;
    logic            illegal;
    fu_e             fu;
    alu_op_e         alu_op;
    br_op_e          br_op;
    lsu_op_e         lsu_op;
    logic            has_rs1;
    logic            has_rs2;
    logic            has_rd;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            is_jump;
    logic            is_word_op;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic [XLEN-1:0] imm;
    logic [PLEN-1:0] pc;
    logic [PLEN-1:0] pred_npc;
  } uop_t;

endpackage

//--- logic/rv_op_decoder.sv
/*
 * Single-lane RV64I+M opcode and funct decoder
 * Produces FU steering, operation enums, operand flags and illegal flag
 */

`timescale 1ns/1ps

module rv_op_decoder (
  input  riscv_isa_pkg::instr_t instr_i,
  output decode_pkg::dec_ctrl_t ctrl_o
);
  import riscv_isa_pkg::*;
  import decode_pkg::*;

  logic rd_nz;  // x0 writes are dropped

  assign rd_nz = |instr_i.rd;

  always_comb begin
    ctrl_o         = '0;
    ctrl_o.fu      = FU_ALU;
    ctrl_o.alu_op  = ALU_NOP;
    ctrl_o.br_op   = BR_EQ;
    ctrl_o.lsu_op  = LSU_LW;
    ctrl_o.imm_fmt = IMM_NONE;

    unique case (instr_i.opcode)
      OPCODE_LUI, OPCODE_AUIPC: begin
        ctrl_o.alu_op  = (instr_i.opcode == OPCODE_LUI) ? ALU_LUI : ALU_AUIPC;
        ctrl_o.has_rd  = rd_nz;
        ctrl_o.imm_fmt = IMM_U;
      end

      OPCODE_JAL: begin
        ctrl_o.fu        = FU_BRANCH;
        ctrl_o.br_op     = BR_JAL;
        ctrl_o.is_jump   = 1'b1;
        ctrl_o.is_branch = 1'b1;
        ctrl_o.has_rd    = rd_nz;
        ctrl_o.imm_fmt   = IMM_J;
      end

      OPCODE_JALR: begin
        ctrl_o.fu        = FU_BRANCH;
        ctrl_o.br_op     = BR_JALR;
        ctrl_o.is_jump   = 1'b1;
        ctrl_o.is_branch = 1'b1;
        ctrl_o.has_rs1   = 1'b1;
        ctrl_o.has_rd    = rd_nz;
        ctrl_o.imm_fmt   = IMM_I;
        ctrl_o.illegal   = (instr_i.funct3 != 3'b000);
      end

      OPCODE_BRANCH: begin
        ctrl_o.fu        = FU_BRANCH;
        ctrl_o.is_branch = 1'b1;
        ctrl_o.has_rs1   = 1'b1;
        ctrl_o.has_rs2   = 1'b1;
        ctrl_o.imm_fmt   = IMM_B;
        unique case (instr_i.funct3)
          3'b000:  ctrl_o.br_op = BR_EQ;
          3'b001:  ctrl_o.br_op = BR_NE;
          3'b100:  ctrl_o.br_op = BR_LT;
          3'b101:  ctrl_o.br_op = BR_GE;
          3'b110:  ctrl_o.br_op = BR_LTU;
          3'b111:  ctrl_o.br_op = BR_GEU;
          default: ctrl_o.illegal = 1'b1;  // 010, 011 unused
        endcase
      end

      OPCODE_LOAD: begin
        ctrl_o.fu      = FU_LSU;
        ctrl_o.is_load = 1'b1;
        ctrl_o.has_rs1 = 1'b1;
        ctrl_o.has_rd  = rd_nz;
        ctrl_o.imm_fmt = IMM_I;
        unique case (instr_i.funct3)
          3'b000:  ctrl_o.lsu_op = LSU_LB;
          3'b001:  ctrl_o.lsu_op = LSU_LH;
          3'b010:  ctrl_o.lsu_op = LSU_LW;
          3'b011:  ctrl_o.lsu_op = LSU_LD;
          3'b100:  ctrl_o.lsu_op = LSU_LBU;
          3'b101:  ctrl_o.lsu_op = LSU_LHU;
          3'b110:  ctrl_o.lsu_op = LSU_LWU;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      OPCODE_STORE: begin
        ctrl_o.fu       = FU_LSU;
        ctrl_o.is_store = 1'b1;
        ctrl_o.has_rs1  = 1'b1;
        ctrl_o.has_rs2  = 1'b1;
        ctrl_o.imm_fmt  = IMM_S;
        unique case (instr_i.funct3)
          3'b000:  ctrl_o.lsu_op = LSU_SB;
          3'b001:  ctrl_o.lsu_op = LSU_SH;
          3'b010:  ctrl_o.lsu_op = LSU_SW;
          3'b011:  ctrl_o.lsu_op = LSU_SD;
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      // funct7[0] is shamt[5] for the 64-bit shifts
      OPCODE_OP_IMM: begin
        ctrl_o.has_rs1 = 1'b1;
        ctrl_o.has_rd  = rd_nz;
        ctrl_o.imm_fmt = IMM_I;
        unique case (instr_i.funct3)
          3'b000: ctrl_o.alu_op = ALU_ADD;
          3'b010: ctrl_o.alu_op = ALU_SLT;
          3'b011: ctrl_o.alu_op = ALU_SLTU;
          3'b100: ctrl_o.alu_op = ALU_XOR;
          3'b110: ctrl_o.alu_op = ALU_OR;
          3'b111: ctrl_o.alu_op = ALU_AND;
          3'b001: begin  // SLLI
            ctrl_o.alu_op  = ALU_SLL;
            ctrl_o.illegal = |instr_i.funct7[6:1];
          end
          default: begin  // SRLI / SRAI
            ctrl_o.alu_op  = instr_i.funct7[5] ? ALU_SRA : ALU_SRL;
            ctrl_o.illegal = instr_i.funct7[6] | (|instr_i.funct7[4:1]);
          end
        endcase
      end

      OPCODE_OP_IMM_32: begin
        ctrl_o.has_rs1    = 1'b1;
        ctrl_o.has_rd     = rd_nz;
        ctrl_o.imm_fmt    = IMM_I;
        ctrl_o.is_word_op = 1'b1;
        unique case (instr_i.funct3)
          3'b000: ctrl_o.alu_op = ALU_ADD;  // ADDIW
          3'b001: begin
            ctrl_o.alu_op  = ALU_SLL;
            ctrl_o.illegal = |instr_i.funct7;
          end
          3'b101: begin
            ctrl_o.alu_op  = instr_i.funct7[5] ? ALU_SRA : ALU_SRL;
            ctrl_o.illegal = instr_i.funct7[6] | (|instr_i.funct7[4:0]);
          end
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      // ----------------------------------------------------------------------
      // Register-register ops, M extension steered by funct7 = 0000001
      // ----------------------------------------------------------------------
      OPCODE_OP: begin
        ctrl_o.has_rs1 = 1'b1;
        ctrl_o.has_rs2 = 1'b1;
        ctrl_o.has_rd  = rd_nz;
        if (instr_i.funct7 == 7'b0000001) begin
          ctrl_o.fu = instr_i.funct3[2] ? FU_DIV : FU_MUL;  // DIV/REM vs MUL*
        end else begin
          unique case ({instr_i.funct7, instr_i.funct3})
            10'b0000000_000: ctrl_o.alu_op = ALU_ADD;
            10'b0100000_000: ctrl_o.alu_op = ALU_SUB;
            10'b0000000_001: ctrl_o.alu_op = ALU_SLL;
            10'b0000000_010: ctrl_o.alu_op = ALU_SLT;
            10'b0000000_011: ctrl_o.alu_op = ALU_SLTU;
            10'b0000000_100: ctrl_o.alu_op = ALU_XOR;
            10'b0000000_101: ctrl_o.alu_op = ALU_SRL;
            10'b0100000_101: ctrl_o.alu_op = ALU_SRA;
            10'b0000000_110: ctrl_o.alu_op = ALU_OR;
            10'b0000000_111: ctrl_o.alu_op = ALU_AND;
            default:         ctrl_o.illegal = 1'b1;
          endcase
        end
      end

      OPCODE_OP_32: begin
        ctrl_o.has_rs1    = 1'b1;
        ctrl_o.has_rs2    = 1'b1;
        ctrl_o.has_rd     = rd_nz;
        ctrl_o.is_word_op = 1'b1;
        unique case ({instr_i.funct7, instr_i.funct3})
          10'b0000000_000: ctrl_o.alu_op = ALU_ADD;
          10'b0100000_000: ctrl_o.alu_op = ALU_SUB;
          10'b0000000_001: ctrl_o.alu_op = ALU_SLL;
          10'b0000000_101: ctrl_o.alu_op = ALU_SRL;
          10'b0100000_101: ctrl_o.alu_op = ALU_SRA;
          10'b0000001_000: ctrl_o.fu = FU_MUL;  // MULW
          10'b0000001_100, 10'b0000001_101,
          10'b0000001_110, 10'b0000001_111: ctrl_o.fu = FU_DIV;  // DIVW..REMUW
          default: ctrl_o.illegal = 1'b1;
        endcase
      end

      // SYSTEM, MISC-MEM and anything else
      default: ctrl_o.illegal = 1'b1;
    endcase
  end

endmodule

//--- logic/imm_gen.sv
/*
 * Immediate generator
 * I/S/B/U/J bit gather and sign extension to XLEN
 */

`timescale 1ns/1ps

module imm_gen (
  input  riscv_isa_pkg::instr_t               instr_i,
  input  riscv_isa_pkg::imm_fmt_e             fmt_i,
  output logic [decode_pkg::XLEN-1:0]         imm_o
);
  import riscv_isa_pkg::*;
  import decode_pkg::*;

  logic [ILEN-1:0] raw;  // Flat view for bit scattering
  logic            sgn;

  assign raw = instr_i;
  assign sgn = raw[31];  // Sign bit sits at [31] for every format

  always_comb begin
    unique case (fmt_i)
      IMM_I: imm_o = {{(XLEN-12){sgn}}, raw[31:20]};
      IMM_S: imm_o = {{(XLEN-12){sgn}}, raw[31:25], raw[11:7]};
      // imm[12|10:5|4:1|11], bit 0 implied zero
      IMM_B: imm_o = {{(XLEN-12){sgn}}, raw[7], raw[30:25], raw[11:8], 1'b0};
      IMM_U: imm_o = {{(XLEN-32){sgn}}, raw[31:12], 12'b0};
      // imm[20|10:1|11|19:12]
      IMM_J: imm_o = {{(XLEN-20){sgn}}, raw[19:12], raw[20], raw[30:21], 1'b0};
      default: imm_o = '0;  // IMM_NONE
    endcase
  end

endmodule

//--- logic/decode_out_reg.sv
/*
 * One-entry output register for the decoded bundle
 * Occupancy bit, valid/ready on both sides, full throughput
 */

`timescale 1ns/1ps

module decode_out_reg (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic                                                in_valid_i,
  output logic                                                in_ready_o,
  input  decode_pkg::uop_t [decode_pkg::DECODE_WIDTH-1:0]     uops_i,
  output logic                                                out_valid_o,
  input  logic                                                out_ready_i,
  output decode_pkg::uop_t [decode_pkg::DECODE_WIDTH-1:0]     uops_o
);
  import decode_pkg::*;

  logic                       full_q;
  logic                       load;
  uop_t [DECODE_WIDTH-1:0]    uops_q;

  // Accept when empty or when the current bundle leaves this cycle
  assign in_ready_o = ~full_q | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (out_ready_i) begin
      full_q <= 1'b0;  // Drained with nothing behind it
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      uops_q <= uops_i;
    end
  end

  assign out_valid_o = full_q;
  assign uops_o      = uops_q;  // Held while stalled

endmodule

//--- logic/decode_top.sv
/*
 * Two-lane decode stage top
 * Per-lane decoder and immediate generator, registered output
 */

`timescale 1ns/1ps

module decode_top (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic                                                ibuf_valid_i,
  output logic                                                ibuf_ready_o,
  input  decode_pkg::fetch_slot_t [decode_pkg::DECODE_WIDTH-1:0] slots_i,
  output logic                                                dec_valid_o,
  input  logic                                                backend_ready_i,
  output decode_pkg::uop_t [decode_pkg::DECODE_WIDTH-1:0]     uops_o
);
  import decode_pkg::*;

  uop_t [DECODE_WIDTH-1:0] uops_d;  // Combinational bundle

  // --------------------------------------------------------------------------
  // Per-lane decode
  // --------------------------------------------------------------------------
  for (genvar g = 0; g < DECODE_WIDTH; g++) begin : gen_lane
    dec_ctrl_t       ctrl;
    logic [XLEN-1:0] imm;

    rv_op_decoder rv_op_decoder_inst (
      .instr_i (slots_i[g].instr),
      .ctrl_o  (ctrl)
    );

    imm_gen imm_gen_inst (
      .instr_i (slots_i[g].instr),
      .fmt_i   (ctrl.imm_fmt),
      .imm_o   (imm)
    );

    assign uops_d[g].valid      = slots_i[g].slot_valid;
    assign uops_d[g].illegal    = ctrl.illegal;
    assign uops_d[g].fu         = ctrl.fu;
    assign uops_d[g].alu_op     = ctrl.alu_op;
    assign uops_d[g].br_op      = ctrl.br_op;
    assign uops_d[g].lsu_op     = ctrl.lsu_op;
    assign uops_d[g].has_rs1    = ctrl.has_rs1;
    assign uops_d[g].has_rs2    = ctrl.has_rs2;
    assign uops_d[g].has_rd     = ctrl.has_rd;
    assign uops_d[g].is_load    = ctrl.is_load;
    assign uops_d[g].is_store   = ctrl.is_store;
    assign uops_d[g].is_branch  = ctrl.is_branch;
    assign uops_d[g].is_jump    = ctrl.is_jump;
    assign uops_d[g].is_word_op = ctrl.is_word_op;
    assign uops_d[g].rs1        = slots_i[g].instr.rs1;
    assign uops_d[g].rs2        = slots_i[g].instr.rs2;
    assign uops_d[g].rd         = slots_i[g].instr.rd;
    assign uops_d[g].imm        = imm;
    assign uops_d[g].pc         = slots_i[g].pc;
    assign uops_d[g].pred_npc   = slots_i[g].pred_npc;
  end

  // One-cycle stage register toward rename
  decode_out_reg decode_out_reg_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (ibuf_valid_i),
    .in_ready_o  (ibuf_ready_o),
    .uops_i      (uops_d),
    .out_valid_o (dec_valid_o),
    .out_ready_i (backend_ready_i),
    .uops_o      (uops_o)
  );

endmodule

//--- include/decode_model.svh
/*
 * Reference decode model for the decode stage testbench
 * ISA immediate assembly, ALU op lookup, per-slot micro-op decode
 */

`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// Keep bits [top:0] of v, copy v[top] into everything above
function automatic logic [XLEN-1:0] sign_extend(input logic [31:0] v, input int top);
  logic [XLEN-1:0] r;
  r = {{(XLEN-32){1'b0}}, v};
  for (int i = top + 1; i < XLEN; i++) begin
    r[i] = v[top];
  end
  return r;
endfunction

function automatic logic [XLEN-1:0] imm_value(input imm_fmt_e fmt, input logic [31:0] w);
  case (fmt)
    IMM_I:   return sign_extend({20'b0, w[31:20]}, 11);
    IMM_S:   return sign_extend({20'b0, w[31:25], w[11:7]}, 11);
    IMM_B:   return sign_extend({19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0}, 12);
    IMM_U:   return sign_extend({w[31:12], 12'b0}, 31);
    IMM_J:   return sign_extend({11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0}, 20);
    default: return '0;
  endcase
endfunction

// alt selects SUB over ADD and SRA over SRL
function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? ALU_SUB : ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return alt ? ALU_SRA : ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

function automatic uop_t model_decode(input fetch_slot_t slot);
  uop_t        u;
  logic [31:0] w;
  logic [6:0]  op;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        r_type;
  imm_fmt_e    fmt;
  w   = slot.instr;
  op  = w[6:0];
  f3  = w[14:12];
  f7  = w[31:25];
  u   = '0;
  fmt = IMM_NONE;
  u.valid      = slot.slot_valid;
  u.rs1        = w[19:15];
  u.rs2        = w[24:20];
  u.rd         = w[11:7];
  u.pc         = slot.pc;
  u.pred_npc   = slot.pred_npc;
  u.lsu_op     = LSU_LW;
  u.is_load    = (op == OPCODE_LOAD);
  u.is_store   = (op == OPCODE_STORE);
  u.is_branch  = op inside {OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH};
  u.is_jump    = op inside {OPCODE_JAL, OPCODE_JALR};
  u.is_word_op = op inside {OPCODE_OP_IMM_32, OPCODE_OP_32};
  u.fu         = u.is_branch ? FU_BRANCH : (u.is_load || u.is_store) ? FU_LSU : FU_ALU;

  case (op)
    OPCODE_LUI: begin
      fmt      = IMM_U;
      u.alu_op = ALU_LUI;
    end
    OPCODE_AUIPC: begin
      fmt      = IMM_U;
      u.alu_op = ALU_AUIPC;
    end
    OPCODE_JAL: begin
      fmt     = IMM_J;
      u.br_op = BR_JAL;
    end
    OPCODE_JALR: begin
      fmt       = IMM_I;
      u.br_op   = BR_JALR;
      u.illegal = (f3 != 3'd0);
    end
    OPCODE_BRANCH: begin
      fmt       = IMM_B;
      u.illegal = (f3[2:1] == 2'b01);
      case (f3)
        3'd0:    u.br_op = BR_EQ;
        3'd1:    u.br_op = BR_NE;
        3'd4:    u.br_op = BR_LT;
        3'd5:    u.br_op = BR_GE;
        3'd6:    u.br_op = BR_LTU;
        default: u.br_op = BR_GEU;
      endcase
    end
    OPCODE_LOAD: begin
      fmt       = IMM_I;
      u.illegal = (f3 == 3'd7);
      u.lsu_op  = lsu_op_e'({1'b0, f3});  // LB..LWU listed in funct3 order
    end
    OPCODE_STORE: begin
      fmt       = IMM_S;
      u.illegal = f3[2];
      case (f3[1:0])
        2'd0:    u.lsu_op = LSU_SB;
        2'd1:    u.lsu_op = LSU_SH;
        2'd2:    u.lsu_op = LSU_SW;
        default: u.lsu_op = LSU_SD;
      endcase
    end
    OPCODE_OP_IMM: begin
      fmt       = IMM_I;
      u.alu_op  = alu_from_f3(f3, (f3 == 3'd5) && w[30]);
      u.illegal = (f3 == 3'd1 && w[31:26] != 6'd0) ||
                  (f3 == 3'd5 && !(w[31:26] inside {6'b000000, 6'b010000}));
    end
    OPCODE_OP_IMM_32: begin
      fmt       = IMM_I;
      u.alu_op  = alu_from_f3(f3, (f3 == 3'd5) && w[30]);
      u.illegal = !(f3 == 3'd0 || (f3 == 3'd1 && f7 == 7'd0) ||
                    (f3 == 3'd5 && f7 inside {7'b0000000, 7'b0100000}));
    end
    OPCODE_OP: begin
      if (f7 == 7'b0000001) begin
        u.fu = f3[2] ? FU_DIV : FU_MUL;
      end else begin
        u.alu_op  = alu_from_f3(f3, w[30]);
        u.illegal = !(f7 == 7'd0 || (f7 == 7'b0100000 && f3 inside {3'd0, 3'd5}));
      end
    end
    OPCODE_OP_32: begin
      if (f7 == 7'b0000001) begin
        u.fu      = (f3 == 3'd0) ? FU_MUL : FU_DIV;  // MULW or DIVW..REMUW
        u.illegal = f3 inside {3'd1, 3'd2, 3'd3};
      end else begin
        u.alu_op  = alu_from_f3(f3, w[30]);
        u.illegal = !((f7 == 7'd0 && f3 inside {3'd0, 3'd1, 3'd5}) ||
                      (f7 == 7'b0100000 && f3 inside {3'd0, 3'd5}));
      end
    end
    default: u.illegal = 1'b1;  // SYSTEM, MISC-MEM, unknown
  endcase

  // Register use follows the encoding format
  r_type    = op inside {OPCODE_OP, OPCODE_OP_32};
  u.has_rs1 = r_type || (fmt inside {IMM_I, IMM_S, IMM_B});
  u.has_rs2 = r_type || (fmt inside {IMM_S, IMM_B});
  u.has_rd  = (r_type || (fmt inside {IMM_I, IMM_U, IMM_J})) && (u.rd != 5'd0);
  u.imm     = imm_value(fmt, w);
  return u;
endfunction

`endif

//--- tb/tb_decode_top.sv
/*
 * Testbench for the two-lane decode stage
 * Random bundles, scoreboard queue against the model, watchdog
 */

`timescale 1ns/1ps

module tb_decode_top;
  import riscv_isa_pkg::*;
  import decode_pkg::*;

  `include "decode_model.svh"

  typedef uop_t [DECODE_WIDTH-1:0] bundle_t;

  localparam int unsigned CLK_PERIOD  = 20;
  localparam int unsigned N_BUNDLES   = 2000;
  localparam int unsigned WATCHDOG_NS = N_BUNDLES * 8 * CLK_PERIOD;

  logic                           clk;
  logic                           rst_n;
  logic                           ibuf_valid;
  logic                           ibuf_ready;
  fetch_slot_t [DECODE_WIDTH-1:0] slots;
  logic                           dec_valid;
  logic                           backend_ready;
  bundle_t                        uops;

  bundle_t exp_q[$];         // Bundles in flight, oldest first
  bundle_t held;
  logic    stalled    = 1'b0;
  int      accepted   = 0;
  int      checked    = 0;
  int      value_errs = 0;
  int      proto_errs = 0;

  decode_top decode_top_inst (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .ibuf_valid_i    (ibuf_valid),
    .ibuf_ready_o    (ibuf_ready),
    .slots_i         (slots),
    .dec_valid_o     (dec_valid),
    .backend_ready_i (backend_ready),
    .uops_o          (uops)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // Compare tasks
  // --------------------------------------------------------------------------
  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
    if (exp !== act) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_fu(input string name, input fu_e exp, input fu_e act);
    if (exp !== act) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_alu(input string name, input alu_op_e exp, input alu_op_e act);
    if (exp !== act) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_br(input string name, input br_op_e exp, input br_op_e act);
    if (exp !== act) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_lsu(input string name, input lsu_op_e exp, input lsu_op_e act);
    if (exp !== act) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_imm(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    if (exp !== act) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_addr(input string name, input logic [PLEN-1:0] exp,
                              input logic [PLEN-1:0] act);
    if (exp !== act) begin
      value_errs++;
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Control fields of an illegal uop are don't care
  task automatic compare_uop(input int lane, input uop_t exp, input uop_t act);
    string p;
    p = $sformatf("uops_o[%0d].", lane);
    compare_flag({p, "valid"}, exp.valid, act.valid);
    compare_flag({p, "illegal"}, exp.illegal, act.illegal);
    compare_reg({p, "rs1"}, exp.rs1, act.rs1);
    compare_reg({p, "rs2"}, exp.rs2, act.rs2);
    compare_reg({p, "rd"}, exp.rd, act.rd);
    compare_addr({p, "pc"}, exp.pc, act.pc);
    compare_addr({p, "pred_npc"}, exp.pred_npc, act.pred_npc);
    if (!exp.illegal) begin
      compare_fu({p, "fu"}, exp.fu, act.fu);
      compare_alu({p, "alu_op"}, exp.alu_op, act.alu_op);
      compare_br({p, "br_op"}, exp.br_op, act.br_op);
      compare_lsu({p, "lsu_op"}, exp.lsu_op, act.lsu_op);
      compare_flag({p, "has_rs1"}, exp.has_rs1, act.has_rs1);
      compare_flag({p, "has_rs2"}, exp.has_rs2, act.has_rs2);
      compare_flag({p, "has_rd"}, exp.has_rd, act.has_rd);
      compare_flag({p, "is_load"}, exp.is_load, act.is_load);
      compare_flag({p, "is_store"}, exp.is_store, act.is_store);
      compare_flag({p, "is_branch"}, exp.is_branch, act.is_branch);
      compare_flag({p, "is_jump"}, exp.is_jump, act.is_jump);
      compare_flag({p, "is_word_op"}, exp.is_word_op, act.is_word_op);
      compare_imm({p, "imm"}, exp.imm, act.imm);
    end
    checked++;
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------
  // Random fields with opcode and funct picked from the legal set
  function automatic logic [31:0] rand_legal_word();
    logic [31:0] w;
    logic [2:0]  f3;
    logic        alt;
    w   = $urandom();
    f3  = 3'($urandom_range(7));
    alt = 1'($urandom_range(1));
    if ($urandom_range(7) == 0) w[11:7] = 5'd0;  // Frequent x0 destination
    case ($urandom_range(10))
      0: w[6:0] = OPCODE_LUI;
      1: w[6:0] = OPCODE_AUIPC;
      2: w[6:0] = OPCODE_JAL;
      3: begin
        w[6:0]   = OPCODE_JALR;
        w[14:12] = 3'd0;
      end
      4: begin
        w[6:0]   = OPCODE_BRANCH;
        w[14:12] = (f3[2:1] == 2'b01) ? {1'b1, f3[1:0]} : f3;
      end
      5: begin
        w[6:0]   = OPCODE_LOAD;
        w[14:12] = (f3 == 3'd7) ? 3'd3 : f3;
      end
      6: begin
        w[6:0]   = OPCODE_STORE;
        w[14:12] = {1'b0, f3[1:0]};
      end
      7: begin
        w[6:0]   = OPCODE_OP_IMM;
        w[14:12] = f3;
        if (f3 == 3'd1) w[31:26] = 6'd0;
        if (f3 == 3'd5) w[31:26] = {1'b0, alt, 4'd0};
      end
      8: begin
        w[6:0]   = OPCODE_OP_IMM_32;
        w[14:12] = (f3[1:0] == 2'd0) ? 3'd0 : (f3[1:0] == 2'd1) ? 3'd1 : 3'd5;
        if (w[14:12] != 3'd0) w[31:25] = {1'b0, alt & w[14], 5'd0};
      end
      9: begin
        w[6:0]   = OPCODE_OP;
        w[14:12] = f3;
        w[31:25] = ($urandom_range(2) == 0) ? 7'b0000001 :
                   {1'b0, alt & (f3 == 3'd0 || f3 == 3'd5), 5'd0};
      end
      default: begin
        w[6:0] = OPCODE_OP_32;
        if ($urandom_range(2) == 0) begin  // MULW, DIVW..REMUW
          w[31:25] = 7'b0000001;
          w[14:12] = (!f3[2] && f3 != 3'd0) ? {1'b1, f3[1:0]} : f3;
        end else begin
          w[14:12] = (f3[1:0] == 2'd0) ? 3'd0 : (f3[1:0] == 2'd1) ? 3'd1 : 3'd5;
          w[31:25] = {1'b0, alt & (w[14:12] != 3'd1), 5'd0};
        end
      end
    endcase
    return w;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] w;
    int unsigned pick;
    pick = $urandom_range(99);
    w    = $urandom();
    if (pick < 60) w = rand_legal_word();
    else if (pick < 75) w[6:0] = 7'b1110011;  // SYSTEM
    else if (pick < 85) w[6:0] = 7'b0001111;  // MISC-MEM
    return w;
  endfunction

  task automatic drive_inputs();
    for (int l = 0; l < DECODE_WIDTH; l++) begin
      slots[l].slot_valid = ($urandom_range(99) < 85);
      slots[l].instr      = rand_word();
      slots[l].pc         = PLEN'({$urandom(), $urandom()});
      slots[l].pred_npc   = PLEN'({$urandom(), $urandom()});
    end
    ibuf_valid    = ($urandom_range(99) < 80);
    backend_ready = ($urandom_range(99) < 70);
  endtask

  function automatic bundle_t model_bundle(input fetch_slot_t [DECODE_WIDTH-1:0] s);
    bundle_t b;
    for (int l = 0; l < DECODE_WIDTH; l++) begin
      b[l] = model_decode(s[l]);
    end
    return b;
  endfunction

  // --------------------------------------------------------------------------
  // Scoreboard sampled mid-cycle ahead of the next rising edge
  // --------------------------------------------------------------------------
  always @(negedge clk) begin
    if (rst_n) begin
      // One-entry stage means valid exactly when one bundle is in flight
      if (dec_valid !== (exp_q.size() != 0)) begin
        proto_errs++;
        $display("[FAIL] dec_valid_o expected %h actual %h at %0t",
                 (exp_q.size() != 0), dec_valid, $time);
      end
      if (ibuf_ready !== (exp_q.size() == 0 || backend_ready)) begin
        proto_errs++;
        $display("[FAIL] ibuf_ready_o expected %h actual %h at %0t",
                 (exp_q.size() == 0 || backend_ready), ibuf_ready, $time);
      end
      if (stalled && (dec_valid !== 1'b1 || uops !== held)) begin
        proto_errs++;
        $display("Output bundle changed while the backend stalled at %0t", $time);
      end
      stalled = dec_valid && !backend_ready;
      held    = uops;
      if (dec_valid && backend_ready && exp_q.size() != 0) begin
        for (int l = 0; l < DECODE_WIDTH; l++) begin
          compare_uop(l, exp_q[0][l], uops[l]);
        end
        void'(exp_q.pop_front());
      end
      if (ibuf_valid && ibuf_ready) begin
        exp_q.push_back(model_bundle(slots));
        accepted++;
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, %0d of %0d bundles accepted, %0d still in flight",
             WATCHDOG_NS, accepted, N_BUNDLES, exp_q.size());
    $display("tests failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h75ce));
    rst_n         = 1'b0;
    ibuf_valid    = 1'b0;
    backend_ready = 1'b0;
    slots         = '0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    while (accepted < N_BUNDLES) begin
      @(posedge clk);
      #2;
      drive_inputs();
    end

    // Drain whatever is still registered
    @(posedge clk);
    #2;
    ibuf_valid    = 1'b0;
    backend_ready = 1'b1;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);

    $display("Checked %0d uops in %0d bundles: %0d value errors, %0d protocol errors",
             checked, accepted, value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
logic/riscv_isa_pkg.sv
logic/decode_pkg.sv
logic/rv_op_decoder.sv
logic/imm_gen.sv
logic/decode_out_reg.sv
logic/decode_top.sv
tb/tb_decode_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, check the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -f compile.f --top-module tb_decode_top \
  -o tb_decode_top || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/tb_decode_top)
echo "$out"
echo "$out" | grep -q "all tests passed" && exit 0 || exit 1
